/* sim.f */
hdl/ahb_pkg.sv
hdl/ahb_arbiter.sv
hdl/ahb_decoder.sv
hdl/ahb_sram.sv
hdl/ahb_timer.sv
hdl/ahb_subsystem.sv
tests/tb_ahb_subsystem.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the AHB subsystem testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing -j 0 -f sim.f --top-module tb_ahb_subsystem -o tb_sim
./obj_dir/tb_sim | tee sim.log

if grep -qF '** PASS **' sim.log; then
   echo "simulation passed"
else
   echo "simulation failed"
   exit 1
fi

/* tests/tb_ahb_subsystem.sv */
/*
 * Testbench for the AHB-Lite subsystem
 * drives both masters with LFSR stimulus, keeps a RAM reference model
 * and checks every read data phase from a separate compare process
 */

`timescale 1ns/1ps

module tb_ahb_subsystem;

   localparam int unsigned     MEM_DEPTH = 512;
   localparam int unsigned     AW        = $clog2(MEM_DEPTH);
   localparam int              TIMEOUT   = 50; // cycles per wait loop
   localparam ahb_pkg::hdata_t CMP_VAL   = 32'd5;
   localparam ahb_pkg::haddr_t T_CTRL    = ahb_pkg::TIMER_BASE;
   localparam ahb_pkg::haddr_t T_CMP     = ahb_pkg::TIMER_BASE + 32'h4;
   localparam ahb_pkg::haddr_t T_COUNT   = ahb_pkg::TIMER_BASE + 32'h8;
   localparam ahb_pkg::haddr_t T_STATUS  = ahb_pkg::TIMER_BASE + 32'hC;

   logic              hclk;
   logic              arst_n;
   logic              irq;
   ahb_pkg::ahb_req_t req [2];
   ahb_pkg::ahb_rsp_t rsp [2];

   // data phase bookkeeping per master
   logic              pend_valid [2];
   logic              pend_wr [2];
   logic              pend_cmp [2];
   ahb_pkg::hdata_t   pend_wdata [2];
   ahb_pkg::hdata_t   pend_exp [2];
   logic              chk_valid [2];  // read data phase in this cycle
   logic              chk_cmp [2];
   ahb_pkg::hdata_t   chk_exp [2];
   ahb_pkg::hdata_t   last_rdata [2];

   ahb_pkg::hdata_t   model [MEM_DEPTH];
   ahb_pkg::haddr_t   addr_q [$];     // every RAM word written so far
   logic [15:0]       lfsr = 16'd13282;
   int                chk_err = 0;
   int                cmp_err = 0;
   int                err_mark = 0;
   int                n_tests = 0;
   int                n_failed = 0;

   ahb_subsystem #(
      .MEM_DEPTH ( MEM_DEPTH ) )
   i_ahb_subsystem (
      .hclk_i   ( hclk   ),
      .arst_n_i ( arst_n ),
      .m0_req_i ( req[0] ),
      .m1_req_i ( req[1] ),
      .m0_rsp_o ( rsp[0] ),
      .m1_rsp_o ( rsp[1] ),
      .irq_o    ( irq    ) );

   initial begin
      hclk = 1'b0;
      forever #2 hclk = ~hclk;
   end

   //////////////////////////////
   // stimulus and reference
   //////////////////////////////

   // 16 bit fibonacci with taps 16 14 13 11
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] v;
      logic        fb;
      int          i;
      v = '0;
      for (i = 0; i < n; i++) begin
         fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
         lfsr = {lfsr[14:0], fb};
         v    = {v[30:0], fb};
      end
      return v;
   endfunction

   function automatic logic is_ram(input ahb_pkg::haddr_t a);
      return (a & ahb_pkg::RAM_MASK) == ahb_pkg::RAM_BASE;
   endfunction

   // expected read value where anything outside the RAM reads zero
   function automatic ahb_pkg::hdata_t ref_read(input ahb_pkg::haddr_t a);
      return is_ram(a) ? model[a[AW+1:2]] : '0;
   endfunction

   task automatic check_data(input string name, input ahb_pkg::hdata_t got,
                             input ahb_pkg::hdata_t exp);
      if (got !== exp) begin
         $display("mismatch %s: got %h expected %h", name, got, exp);
         cmp_err++;
      end
   endtask

   task automatic check_bit(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         $display("mismatch %s: got %h expected %h", name, got, exp);
         chk_err++;
      end
   endtask

   task automatic abort_run(input string what);
      $display("timeout: %s", what);
      $display("** FAIL **");
      $finish;
   endtask

   task automatic end_test(input string name);
      int errs;
      errs     = chk_err + cmp_err - err_mark;
      err_mark = chk_err + cmp_err;
      n_tests++;
      if (errs == 0) begin
         $display("test %s: ok", name);
      end else begin
         n_failed++;
         $display("test %s: %0d errors", name, errs);
      end
   endtask

   // hwdata of the last accepted transfer and the read check for it
   task automatic start_dphase(input int m);
      req[m].hwdata = pend_wdata[m];
      chk_valid[m]  = pend_valid[m] && !pend_wr[m];
      chk_cmp[m]    = pend_cmp[m];
      chk_exp[m]    = pend_exp[m];
      pend_valid[m] = 1'b0;
   endtask

   task automatic xfer(input int m, input logic wr, input ahb_pkg::haddr_t a,
                       input ahb_pkg::hdata_t d, input logic cmp, output int stalls);
      stalls = 0;
      @(posedge hclk);
      #1;
      start_dphase(m);
      req[m].htrans = ahb_pkg::NONSEQ;
      req[m].haddr  = a;
      req[m].hwrite = wr;
      @(negedge hclk);
      while (!rsp[m].hready) begin // lost the bus so the address is held
         if (stalls == TIMEOUT) abort_run($sformatf("master %0d never got hready", m));
         stalls++;
         @(posedge hclk);
         #1;
         start_dphase(m);
         @(negedge hclk);
      end
      pend_valid[m] = 1'b1;
      pend_wr[m]    = wr;
      pend_wdata[m] = d;
      pend_cmp[m]   = cmp;
      pend_exp[m]   = wr ? '0 : ref_read(a);
      if (wr && is_ram(a)) model[a[AW+1:2]] = d;
   endtask

   task automatic idle_cycles(input int m, input int n);
      repeat (n) begin
         @(posedge hclk);
         #1;
         start_dphase(m);
         req[m].htrans = ahb_pkg::IDLE;
         @(negedge hclk);
      end
   endtask

   task automatic read_word(input ahb_pkg::haddr_t a, output ahb_pkg::hdata_t d);
      int s;
      xfer(0, 1'b0, a, '0, 1'b0, s);
      idle_cycles(0, 2);
      d = last_rdata[0];
   endtask

   //////////////////////////////
   // compare process
   //////////////////////////////

   initial begin
      int m;
      forever begin
         @(negedge hclk);
         for (m = 0; m < 2; m++) begin
            if (chk_valid[m]) begin
               last_rdata[m] = rsp[m].hrdata;
               if (chk_cmp[m])
                  check_data(m == 0 ? "m0_rsp_o.hrdata" : "m1_rsp_o.hrdata",
                             rsp[m].hrdata, chk_exp[m]);
            end
         end
      end
   end

   //////////////////////////////
   // tests
   //////////////////////////////

   initial begin
      int              st;
      int              st0;
      int              m1_stalls;
      int              n;
      ahb_pkg::haddr_t a;
      ahb_pkg::haddr_t a0 [3];
      ahb_pkg::haddr_t a1;
      ahb_pkg::hdata_t d0 [3];
      ahb_pkg::hdata_t d1;
      ahb_pkg::hdata_t v;
      arst_n = 1'b0;
      for (n = 0; n < 2; n++) begin
         req[n]        = '0; // htrans IDLE
         pend_valid[n] = 1'b0;
         pend_wr[n]    = 1'b0;
         pend_cmp[n]   = 1'b0;
         pend_wdata[n] = '0;
         pend_exp[n]   = '0;
         chk_valid[n]  = 1'b0;
         chk_cmp[n]    = 1'b0;
         chk_exp[n]    = '0;
         last_rdata[n] = '0;
      end
      repeat (5) @(posedge hclk);
      #1;
      arst_n = 1'b1;
      @(negedge hclk);
      check_bit("m0_rsp_o.hready", rsp[0].hready, 1'b1);
      check_bit("m1_rsp_o.hready", rsp[1].hready, 1'b1);
      check_bit("irq_o", irq, 1'b0);
      end_test("reset state");

      // back-to-back writes then pipelined reads
      for (n = 0; n < 8; n++) begin
         a = ahb_pkg::RAM_BASE | (rand_bits(AW) << 2);
         addr_q.push_back(a);
         xfer(0, 1'b1, a, rand_bits(32), 1'b0, st);
      end
      for (n = 0; n < addr_q.size(); n++) xfer(0, 1'b0, addr_q[n], '0, 1'b1, st);
      idle_cycles(0, 2);
      end_test("ram master 0");

      for (n = 0; n < 3; n++) begin
         a0[n] = ahb_pkg::RAM_BASE | (rand_bits(AW) << 2);
         d0[n] = rand_bits(32);
         addr_q.push_back(a0[n]);
      end
      a1 = ahb_pkg::RAM_BASE | (rand_bits(AW) << 2);
      d1 = rand_bits(32);
      addr_q.push_back(a1);
      fork
         begin
            for (n = 0; n < 3; n++) xfer(0, 1'b1, a0[n], d0[n], 1'b0, st0);
            idle_cycles(0, 2);
         end
         begin
            xfer(1, 1'b1, a1, d1, 1'b0, m1_stalls);
            idle_cycles(1, 2);
         end
         begin
            @(negedge hclk); // first cycle with both NONSEQ
            check_bit("m1_rsp_o.hready", rsp[1].hready, 1'b0);
         end
      join
      if (m1_stalls != 3) begin
         $display("master 1 waited %0d cycles instead of 3", m1_stalls);
         chk_err++;
      end
      xfer(0, 1'b0, a1, '0, 1'b1, st);
      idle_cycles(0, 2);
      for (n = 0; n < 3; n++) xfer(1, 1'b0, a0[n], '0, 1'b1, st);
      idle_cycles(1, 2);
      end_test("contention");

      // unmapped alias of a written RAM word
      a = 32'h6000_0000 | (addr_q[0] & ~ahb_pkg::RAM_MASK);
      xfer(0, 1'b0, a, '0, 1'b1, st);
      xfer(0, 1'b1, a, rand_bits(32), 1'b0, st);
      for (n = 0; n < addr_q.size(); n++) xfer(0, 1'b0, addr_q[n], '0, 1'b1, st);
      idle_cycles(0, 2);
      end_test("unmapped");

      xfer(0, 1'b1, T_CMP, CMP_VAL, 1'b0, st);
      xfer(0, 1'b1, T_CTRL, 32'd1, 1'b0, st);
      idle_cycles(0, 2);
      v = '0;
      n = 0;
      while (!v[0]) begin
         if (n == TIMEOUT) abort_run("timer status bit never set");
         n++;
         read_word(T_STATUS, v);
      end
      check_bit("irq_o", irq, 1'b1);
      read_word(T_COUNT, v);
      if (v > CMP_VAL) begin
         $display("timer count %0d is above the compare value %0d", v, CMP_VAL);
         chk_err++;
      end
      xfer(0, 1'b1, T_CTRL, 32'd0, 1'b0, st);   // stop further matches
      xfer(0, 1'b1, T_STATUS, 32'd1, 1'b0, st);
      idle_cycles(0, 2);
      check_bit("irq_o", irq, 1'b0);
      read_word(T_STATUS, v);
      check_bit("status bit 0", v[0], 1'b0);
      end_test("timer");

      $display("tests %0d, failed %0d, errors %0d", n_tests, n_failed, chk_err + cmp_err);
      if (chk_err + cmp_err == 0) begin
         $display("** PASS **");
      end else begin
         $display("** FAIL **");
      end
      $finish;
   end

endmodule

/* hdl/ahb_subsystem.sv */
/*
 * AHB-Lite subsystem, two masters and two slaves
 * fixed-priority arbiter, address decoder, word SRAM and timer
 */

`timescale 1ns/1ps

module ahb_subsystem #(
   parameter int unsigned MEM_DEPTH = 512
) (
   input  logic              hclk_i,
   input  logic              arst_n_i,
   input  ahb_pkg::ahb_req_t m0_req_i,  // core side, high priority
   input  ahb_pkg::ahb_req_t m1_req_i,  // dma side, low priority
   output ahb_pkg::ahb_rsp_t m0_rsp_o,
   output ahb_pkg::ahb_rsp_t m1_rsp_o,
   output logic              irq_o
);

   ahb_pkg::ahb_req_t bus_req;
   ahb_pkg::hdata_t   bus_rdata;
   ahb_pkg::hdata_t   ram_rdata;
   ahb_pkg::hdata_t   timer_rdata;
   logic              ram_sel;
   logic              timer_sel;

   ///////////////////////////////
   // fabric
   ///////////////////////////////

   ahb_arbiter i_ahb_arbiter (
      .hclk_i      ( hclk_i    ),
      .arst_n_i    ( arst_n_i  ),
      .m0_req_i    ( m0_req_i  ),
      .m1_req_i    ( m1_req_i  ),
      .bus_rdata_i ( bus_rdata ),
      .bus_req_o   ( bus_req   ),
      .m0_rsp_o    ( m0_rsp_o  ),
      .m1_rsp_o    ( m1_rsp_o  ) );

   ahb_decoder i_ahb_decoder (
      .hclk_i        ( hclk_i      ),
      .arst_n_i      ( arst_n_i    ),
      .bus_req_i     ( bus_req     ),
      .ram_rdata_i   ( ram_rdata   ),
      .timer_rdata_i ( timer_rdata ),
      .ram_sel_o     ( ram_sel     ),
      .timer_sel_o   ( timer_sel   ),
      .bus_rdata_o   ( bus_rdata   ) );

   ///////////////////////////////
   // slaves
   ///////////////////////////////

   ahb_sram #(
      .MEM_DEPTH ( MEM_DEPTH ) )
   i_ahb_sram (
      .hclk_i    ( hclk_i    ),
      .arst_n_i  ( arst_n_i  ),
      .sel_i     ( ram_sel   ),
      .bus_req_i ( bus_req   ),
      .rdata_o   ( ram_rdata ) );

   ahb_timer i_ahb_timer (
      .hclk_i    ( hclk_i      ),
      .arst_n_i  ( arst_n_i    ),
      .sel_i     ( timer_sel   ),
      .bus_req_i ( bus_req     ),
      .rdata_o   ( timer_rdata ),
      .irq_o     ( irq_o       ) );  // to the core irq line

endmodule

/* hdl/ahb_timer.sv */
/*
 * AHB-Lite compare-match timer
 * counter runs while enabled, wraps to zero on compare match and
 * sets a pending bit that drives the interrupt line
 */

`timescale 1ns/1ps

module ahb_timer (
   input  logic              hclk_i,
   input  logic              arst_n_i,
   input  logic              sel_i,
   input  ahb_pkg::ahb_req_t bus_req_i,
   output ahb_pkg::hdata_t   rdata_o,
   output logic              irq_o
);

   ahb_pkg::timer_reg_e dp_reg; // register of the data phase
   logic                dp_valid;
   logic                dp_write;
   logic                enable;
   ahb_pkg::hdata_t     cmp;
   ahb_pkg::hdata_t     count;
   logic                pending;

   always_ff @(posedge hclk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         dp_valid <= 1'b0;
         dp_write <= 1'b0;
      end else begin
         dp_valid <= sel_i;
         dp_write <= sel_i & bus_req_i.hwrite;
      end
   end

   always_ff @(posedge hclk_i) begin
      if (sel_i) dp_reg <= ahb_pkg::timer_reg_e'(bus_req_i.haddr[3:2]);
   end

   ///////////////////////////////
   // registers and counter
   ///////////////////////////////

   always_ff @(posedge hclk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         enable  <= 1'b0;
         cmp     <= '0;
         count   <= '0;
         pending <= 1'b0;
      end else begin
         if (dp_write) begin
            case (dp_reg)
               ahb_pkg::REG_CTRL:   enable <= bus_req_i.hwdata[0];
               ahb_pkg::REG_CMP:    cmp    <= bus_req_i.hwdata;
               ahb_pkg::REG_STATUS: if (bus_req_i.hwdata[0]) pending <= 1'b0;
               default: ; // count is read only
            endcase
         end
         if (enable) begin
            if (count == cmp) begin
               count   <= '0;
               pending <= 1'b1; // a new match beats a clear
            end else begin
               count <= count + 1'b1;
            end
         end
      end
   end

   always_comb begin
      case (dp_reg)
         ahb_pkg::REG_CTRL:   rdata_o = {31'b0, enable};
         ahb_pkg::REG_CMP:    rdata_o = cmp;
         ahb_pkg::REG_COUNT:  rdata_o = count;
         default:             rdata_o = {31'b0, pending};
      endcase
      if (!dp_valid) rdata_o = '0;
   end

   assign irq_o = pending;

endmodule

/* hdl/ahb_sram.sv */
/*
 * Zero-wait AHB-Lite word SRAM
 * address captured in the address phase, written or read in the
 * data phase one cycle later
 */

`timescale 1ns/1ps

module ahb_sram #(
   parameter int unsigned MEM_DEPTH = 512
) (
   input  logic              hclk_i,
   input  logic              arst_n_i,
   input  logic              sel_i,
   input  ahb_pkg::ahb_req_t bus_req_i,
   output ahb_pkg::hdata_t   rdata_o
);

   localparam int unsigned AW = $clog2(MEM_DEPTH);

   ahb_pkg::hdata_t mem [MEM_DEPTH];
   logic [AW-1:0]   dp_addr;  // word address of the data phase
   logic            dp_valid;
   logic            dp_write;

   always_ff @(posedge hclk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         dp_valid <= 1'b0;
         dp_write <= 1'b0;
      end else begin
         dp_valid <= sel_i;
         dp_write <= sel_i & bus_req_i.hwrite;
      end
   end

   always_ff @(posedge hclk_i) begin
      if (sel_i) dp_addr <= bus_req_i.haddr[AW+1:2]; // byte to word
   end

   always_ff @(posedge hclk_i) begin
      if (dp_write) mem[dp_addr] <= bus_req_i.hwdata;
   end

   assign rdata_o = dp_valid ? mem[dp_addr] : '0;

endmodule

/* hdl/ahb_decoder.sv */
/*
 * AHB-Lite address decoder
 * mask/base match into slave selects, plus the read-data
 * multiplexer driven by the slave of the current data phase
 */

`timescale 1ns/1ps

module ahb_decoder (
   input  logic              hclk_i,
   input  logic              arst_n_i,
   input  ahb_pkg::ahb_req_t bus_req_i,
   input  ahb_pkg::hdata_t   ram_rdata_i,
   input  ahb_pkg::hdata_t   timer_rdata_i,
   output logic              ram_sel_o,
   output logic              timer_sel_o,
   output ahb_pkg::hdata_t   bus_rdata_o
);

   logic             nonseq;
   ahb_pkg::slave_e  addr_slave; // target of the address phase
   ahb_pkg::slave_e  dp_slave;   // target of the data phase

   assign nonseq = (bus_req_i.htrans == ahb_pkg::NONSEQ);

   ///////////////////////////////
   // address match
   ///////////////////////////////

   always_comb begin
      if ((bus_req_i.haddr & ahb_pkg::RAM_MASK) == ahb_pkg::RAM_BASE) begin
         addr_slave = ahb_pkg::SLV_RAM;
      end else if ((bus_req_i.haddr & ahb_pkg::TIMER_MASK) == ahb_pkg::TIMER_BASE) begin
         addr_slave = ahb_pkg::SLV_TIMER;
      end else begin
         addr_slave = ahb_pkg::SLV_NONE; // unmapped, reads zero
      end
   end

   assign ram_sel_o   = nonseq && (addr_slave == ahb_pkg::SLV_RAM);
   assign timer_sel_o = nonseq && (addr_slave == ahb_pkg::SLV_TIMER);

   always_ff @(posedge hclk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         dp_slave <= ahb_pkg::SLV_NONE;
      end else begin
         dp_slave <= nonseq ? addr_slave : ahb_pkg::SLV_NONE;
      end
   end

   ///////////////////////////////
   // read mux
   ///////////////////////////////

   always_comb begin
      case (dp_slave)
         ahb_pkg::SLV_RAM:   bus_rdata_o = ram_rdata_i;
         ahb_pkg::SLV_TIMER: bus_rdata_o = timer_rdata_i;
         default:            bus_rdata_o = '0;
      endcase
   end

endmodule

/* hdl/ahb_arbiter.sv */
/*
 * Two-master AHB-Lite arbiter, fixed priority
 * master 0 wins the address phase whenever it presents NONSEQ;
 * the data-phase owner is tracked to steer hwdata and hrdata
 */

`timescale 1ns/1ps

module ahb_arbiter (
   input  logic              hclk_i,
   input  logic              arst_n_i,
   input  ahb_pkg::ahb_req_t m0_req_i,
   input  ahb_pkg::ahb_req_t m1_req_i,
   input  ahb_pkg::hdata_t   bus_rdata_i,
   output ahb_pkg::ahb_req_t bus_req_o,
   output ahb_pkg::ahb_rsp_t m0_rsp_o,
   output ahb_pkg::ahb_rsp_t m1_rsp_o
);

   typedef enum logic [1:0] {
      OWN_NONE = 2'd0,
      OWN_M0   = 2'd1,
      OWN_M1   = 2'd2
   } owner_e;

   logic   m0_nonseq;
   logic   m1_nonseq;
   logic   grant_m0;
   owner_e dp_owner; // who owns the data phase now

   assign m0_nonseq = (m0_req_i.htrans == ahb_pkg::NONSEQ);
   assign m1_nonseq = (m1_req_i.htrans == ahb_pkg::NONSEQ);
   assign grant_m0  = m0_nonseq;

   ///////////////////////////////
   // address phase
   ///////////////////////////////

   assign bus_req_o.htrans = grant_m0 ? m0_req_i.htrans : m1_req_i.htrans;
   assign bus_req_o.haddr  = grant_m0 ? m0_req_i.haddr  : m1_req_i.haddr;
   assign bus_req_o.hwrite = grant_m0 ? m0_req_i.hwrite : m1_req_i.hwrite;

   // stall only a NONSEQ that lost the bus
   assign m0_rsp_o.hready = grant_m0 | ~m0_nonseq;
   assign m1_rsp_o.hready = ~grant_m0 | ~m1_nonseq;

   always_ff @(posedge hclk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         dp_owner <= OWN_NONE;
      end else if (m0_nonseq) begin
         dp_owner <= OWN_M0;
      end else if (m1_nonseq) begin
         dp_owner <= OWN_M1;
      end else begin
         dp_owner <= OWN_NONE;
      end
   end

   ///////////////////////////////
   // data phase
   ///////////////////////////////

   assign bus_req_o.hwdata = (dp_owner == OWN_M0) ? m0_req_i.hwdata :
                             (dp_owner == OWN_M1) ? m1_req_i.hwdata : '0;

   assign m0_rsp_o.hrdata = (dp_owner == OWN_M0) ? bus_rdata_i : '0;
   assign m1_rsp_o.hrdata = (dp_owner == OWN_M1) ? bus_rdata_i : '0;

endmodule

/* hdl/ahb_pkg.sv */
/*
 * AHB-Lite bus fabric definitions
 * widths, transfer and timer register encodings, master request and
 * response structs, and the fixed slave address map
 */

package ahb_pkg;

   ///////////////////////////////
   // widths
   ///////////////////////////////

   typedef logic [31:0] haddr_t;
   typedef logic [31:0] hdata_t;

   ///////////////////////////////
   // encodings
   ///////////////////////////////

   typedef enum logic [1:0] {
      IDLE   = 2'b00,
      BUSY   = 2'b01,
      NONSEQ = 2'b10,
      SEQ    = 2'b11
   } htrans_e;

   typedef enum logic [1:0] {
      SLV_RAM   = 2'd0,
      SLV_TIMER = 2'd1,
      SLV_NONE  = 2'd2
   } slave_e;

   // timer register index, haddr[3:2]
   typedef enum logic [1:0] {
      REG_CTRL   = 2'd0, // bit 0 enable
      REG_CMP    = 2'd1, // compare value
      REG_COUNT  = 2'd2, // read only
      REG_STATUS = 2'd3  // bit 0 irq pending, write 1 to clear
   } timer_reg_e;

   ///////////////////////////////
   // bus structs
   ///////////////////////////////

   typedef struct packed {
      htrans_e htrans; // address phase
      haddr_t  haddr;
      logic    hwrite;
      hdata_t  hwdata; // data phase
   } ahb_req_t;

   typedef struct packed {
      hdata_t hrdata;
      logic   hready;
   } ahb_rsp_t;

   // slave map, match when (haddr & mask) == base
   localparam haddr_t RAM_BASE   = 32'h2000_0000;
   localparam haddr_t RAM_MASK   = 32'hE000_0000;
   localparam haddr_t TIMER_BASE = 32'h4000_0400;
   localparam haddr_t TIMER_MASK = 32'hFFFF_FFC0;

endpackage
